//--- verilog.f
+incdir+hdl
hdl/dual_issue_pkg.sv
hdl/uop_decode.sv
hdl/regfile_read.sv
hdl/alu_execute.sv
hdl/result_writeback.sv
hdl/dual_issue_core.sv
testbench/tb_clock_gen.sv
testbench/tb_dual_issue.sv

//--- Makefile
VERILATOR   = verilator
VFLAGS      = --binary --timing -Ihdl
LINT_FLAGS  = --lint-only --timing -Wall -Ihdl
TOP         = tb_dual_issue
RTL_TOP     = dual_issue_core
FILELIST    = verilog.f
LOG         = sim.log
PASS_TEXT   = Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	-./obj_dir/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf obj_dir $(LOG)

//--- testbench/tb_dual_issue.sv
`timescale 1ns/1ps

module tb_dual_issue import dual_issue_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        stall;
    logic        flush;
    logic        issue_hold;
    issue_pkt_t  issue0;
    issue_pkt_t  issue1;
    commit_t     commit0;
    commit_t     commit1;
    issue_pkt_t  row_p0[$];
    issue_pkt_t  row_p1[$];
    bit          row_stall[$];
    bit          row_flush[$];
    logic [31:0] model_rf [0:31];
    commit_t     exp_q[$];
    bit          cnt_q[$];
    bit          last_stall;
    bit          hold_expected;
    bit          table_ready;
    int          edge_no;
    int          last_accept_edge;
    issue_pkt_t  last_lane0;
    logic [31:0] last_cnt;
    bit          cnt_seen;

    tb_clock_gen #(.PERIOD_NS(8), .RESET_CYCLES(3)) i_clk_gen (.clk(clk), .rst_n(rst_n));

    dual_issue_core i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .flush      (flush),
        .issue0     (issue0),
        .issue1     (issue1),
        .issue_hold (issue_hold),
        .commit0    (commit0),
        .commit1    (commit1)
    );

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic issue_pkt_t pkt(input opcode_e op, input logic [4:0] rd,
                                       input logic [4:0] rj, input logic [4:0] rk,
                                       input logic [31:0] imm);
        issue_pkt_t p;
        p = '0;
        p.valid  = 1'b1;
        p.opcode = op;
        p.rd     = rd;
        p.rj     = rj;
        p.rk     = rk;
        p.imm    = imm;
        return p;
    endfunction

    task automatic add_row(input issue_pkt_t p0, input issue_pkt_t p1, input bit st,
                           input bit fl);
        int n;
        n = row_p0.size();
        p0.pc = 32'h1000 + n * 8;
        p1.pc = 32'h1004 + n * 8;
        row_p0.push_back(p0);
        row_p1.push_back(p1);
        row_stall.push_back(st);
        row_flush.push_back(fl);
    endtask

    function automatic logic [31:0] reg_val(input logic [4:0] r);
        return (r == 5'd0) ? 32'd0 : model_rf[r];
    endfunction

    function automatic bit reads(input issue_pkt_t p, input logic [4:0] r);
        bit use_rj;
        bit use_rk;
        use_rk = p.opcode inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT, OP_MUL};
        use_rj = use_rk || p.opcode == OP_ADDI;
        return p.valid && ((use_rj && p.rj == r) || (use_rk && p.rk == r));
    endfunction

    function automatic commit_t expect_commit(input issue_pkt_t p);
        commit_t     c;
        logic [31:0] a;
        logic [31:0] b;
        c = '0;
        a = reg_val(p.rj);
        b = reg_val(p.rk);
        c.valid = p.valid;
        if (p.valid) begin
            c.writes_rd = p.opcode != OP_NOP;
            c.rd        = p.rd;
            c.pc        = p.pc;
            case (p.opcode)
                OP_ADD:    c.data = a + b;
                OP_SUB:    c.data = a - b;
                OP_AND:    c.data = a & b;
                OP_OR:     c.data = a | b;
                OP_XOR:    c.data = a ^ b;
                OP_SLT:    c.data = {31'd0, $signed(a) < $signed(b)};
                OP_ADDI:   c.data = a + p.imm;
                OP_LU12I:  c.data = {p.imm[19:0], 12'd0};
                OP_PCADDI: c.data = p.pc + p.imm;
                OP_MUL:    c.data = a * b;
                default:   c.data = 32'd0;
            endcase
        end
        return c;
    endfunction

    task automatic check_commit(input string name, input commit_t got, input commit_t exp,
                                input bit skip_data);
        bit bad;
        bad = got.valid !== exp.valid;
        if (exp.valid && !bad) begin
            bad = got.writes_rd !== exp.writes_rd || got.rd !== exp.rd || got.pc !== exp.pc;
            if (exp.writes_rd && !skip_data && got.data !== exp.data) begin
                bad = 1'b1;
            end
        end
        if (bad) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_hold(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail at %0t: issue_hold got %b expected %b", $time, got, exp);
            stop_run();
        end
    endtask

    // predictions happen at accept time, in program order
    task automatic record_accept(input int i);
        int      n;
        bit      squash;
        commit_t c0;
        commit_t c1;
        n = row_p0.size();
        squash = row_flush[i] || (i + 1 < n && row_flush[i + 1]) ||
                 (i + 2 < n && row_flush[i + 2]);
        hold_expected = edge_no == last_accept_edge + 1 && last_lane0.valid &&
                        last_lane0.opcode == OP_MUL && last_lane0.rd != 5'd0 &&
                        (reads(row_p0[i], last_lane0.rd) || reads(row_p1[i], last_lane0.rd));
        last_accept_edge = edge_no;
        last_lane0 = row_p0[i];
        if (!squash && (row_p0[i].valid || row_p1[i].valid)) begin
            c0 = expect_commit(row_p0[i]);
            c1 = expect_commit(row_p1[i]);
            exp_q.push_back(c0);
            exp_q.push_back(c1);
            cnt_q.push_back(row_p0[i].valid && row_p0[i].opcode == OP_RDCNTL);
            cnt_q.push_back(row_p1[i].valid && row_p1[i].opcode == OP_RDCNTL);
            // lane 1 lands last, so it wins a shared rd
            if (c0.valid && c0.writes_rd && c0.rd != 5'd0) model_rf[c0.rd] = c0.data;
            if (c1.valid && c1.writes_rd && c1.rd != 5'd0) model_rf[c1.rd] = c1.data;
        end
    endtask

    task automatic apply_row(input int i);
        bit accepted;
        accepted = 1'b0;
        issue0 <= row_p0[i];
        issue1 <= row_p1[i];
        stall  <= row_stall[i];
        flush  <= row_flush[i];
        while (!accepted) begin
            @(negedge clk);
            check_hold(issue_hold, hold_expected);
            hold_expected = 1'b0;
            accepted = !stall && !issue_hold;
            @(posedge clk);
            edge_no++;
            if (accepted) begin
                record_accept(i);
            end else if (stall) begin
                stall <= 1'b0;
            end
        end
    endtask

    task automatic check_counter(input logic [31:0] val);
        if (cnt_seen && val <= last_cnt) begin
            $display("Error at %0t: rdcntl value %h is not above the previous %h",
                     $time, val, last_cnt);
            stop_run();
        end
        last_cnt = val;
        cnt_seen = 1'b1;
    endtask

    task automatic check_pair();
        commit_t e0;
        commit_t e1;
        bit      k0;
        bit      k1;
        if (exp_q.size() < 2) begin
            $display("Error at %0t: commit seen with none expected", $time);
            stop_run();
        end
        e0 = exp_q.pop_front();
        e1 = exp_q.pop_front();
        k0 = cnt_q.pop_front();
        k1 = cnt_q.pop_front();
        check_commit("commit0", commit0, e0, k0);
        check_commit("commit1", commit1, e1, k1);
        if (k0) check_counter(commit0.data);
        if (k1) check_counter(commit1.data);
    endtask

    // a held commit is counted on its first window only
    always @(posedge clk) last_stall <= stall;

    always @(negedge clk) begin
        if (rst_n && !last_stall && (commit0.valid || commit1.valid)) begin
            check_pair();
        end
    end

    initial begin
        wait (table_ready);
        repeat (row_p0.size() * 20) @(posedge clk);
        $display("Error: timeout, pipeline did not drain");
        stop_run();
    end

    initial begin
        issue_pkt_t idle;
        idle = '0;
        stall = 1'b0;
        flush = 1'b0;
        issue0 = '0;
        issue1 = '0;
        last_accept_edge = -10;
        last_lane0 = '0;
        for (int r = 0; r < 32; r++) model_rf[r] = 32'd0;
        void'($urandom(32'he6e5));
        add_row(pkt(OP_ADDI, 1, 0, 0, $urandom), pkt(OP_ADDI, 2, 0, 0, $urandom), 0, 0);
        add_row(pkt(OP_ADD, 3, 1, 2, 0), pkt(OP_SUB, 4, 1, 2, 0), 0, 0);
        add_row(pkt(OP_AND, 5, 3, 4, 0), pkt(OP_XOR, 6, 3, 1, 0), 0, 0);
        add_row(pkt(OP_OR, 7, 5, 6, 0), pkt(OP_SLT, 8, 4, 3, 0), 0, 0);
        add_row(pkt(OP_LU12I, 9, 0, 0, $urandom), pkt(OP_PCADDI, 10, 0, 0, $urandom), 0, 0);
        add_row(pkt(OP_ADDI, 0, 1, 0, $urandom), pkt(OP_ADD, 11, 0, 9, 0), 0, 0);
        add_row(pkt(OP_ADD, 12, 0, 10, 0), pkt(OP_ADDI, 1, 1, 0, $urandom), 0, 0);
        add_row(pkt(OP_ADD, 13, 1, 12, 0), pkt(OP_SUB, 14, 12, 1, 0), 0, 0);
        // multiply with a reader right behind it
        add_row(pkt(OP_MUL, 15, 1, 2, 0), pkt(OP_ADDI, 16, 3, 0, 5), 0, 0);
        add_row(pkt(OP_ADD, 17, 15, 1, 0), pkt(OP_OR, 18, 15, 16, 0), 0, 0);
        add_row(pkt(OP_MUL, 19, 2, 3, 0), pkt(OP_ADDI, 20, 4, 0, $urandom), 0, 0);
        add_row(pkt(OP_XOR, 21, 5, 6, 0), pkt(OP_ADDI, 22, 7, 0, 1), 0, 0);
        add_row(pkt(OP_ADD, 23, 19, 1, 0), idle, 0, 0);
        add_row(pkt(OP_ADDI, 24, 0, 0, 1), pkt(OP_ADDI, 24, 0, 0, 2), 0, 0);
        add_row(pkt(OP_ADD, 25, 24, 0, 0), pkt(OP_RDCNTL, 31, 0, 0, 0), 0, 0);
        add_row(pkt(OP_RDCNTH, 26, 0, 0, 0), pkt(OP_ADDI, 27, 25, 0, $urandom), 1, 0);
        add_row(pkt(OP_RDCNTL, 31, 0, 0, 0), pkt(OP_ADD, 28, 26, 27, 0), 0, 0);
        add_row(pkt(OP_ADDI, 2, 0, 0, $urandom), pkt(OP_ADDI, 3, 2, 0, 7), 0, 0);
        add_row(pkt(OP_ADD, 4, 2, 3, 0), pkt(OP_RDCNTL, 31, 0, 0, 0), 1, 0);
        // these two rows are squashed by the flush row
        add_row(pkt(OP_ADDI, 5, 0, 0, $urandom), pkt(OP_ADDI, 6, 0, 0, $urandom), 0, 0);
        add_row(pkt(OP_ADD, 1, 5, 6, 0), pkt(OP_ADDI, 7, 0, 0, 99), 0, 0);
        add_row(idle, idle, 0, 1);
        add_row(pkt(OP_ADD, 29, 5, 6, 0), pkt(OP_ADD, 30, 1, 7, 0), 0, 0);
        add_row(pkt(OP_RDCNTL, 31, 0, 0, 0), pkt(OP_ADD, 11, 29, 30, 0), 0, 0);
        table_ready = 1'b1;

        wait (rst_n);
        @(posedge clk);
        edge_no = 1;
        for (int i = 0; i < row_p0.size(); i++) apply_row(i);
        issue0 <= '0;
        issue1 <= '0;
        flush  <= 1'b0;
        while (exp_q.size() > 0) @(posedge clk);
        repeat (4) @(posedge clk);
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 3
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- hdl/dual_issue_core.sv
`timescale 1ns/1ps

module dual_issue_core
    import dual_issue_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       flush,
    input  issue_pkt_t issue0,
    input  issue_pkt_t issue1,
    output logic       issue_hold,
    output commit_t    commit0,
    output commit_t    commit1
);

    uop_t       dec0;
    uop_t       dec1;
    operand_t   opr0;
    operand_t   opr1;
    ex_result_t ex0;
    ex_result_t ex1;
    commit_t    wr0;
    commit_t    wr1;
    logic       hazard_hold;

    uop_decode i_decode (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .hazard_hold (hazard_hold),
        .issue0      (issue0),
        .issue1      (issue1),
        .dec0        (dec0),
        .dec1        (dec1)
    );

    regfile_read i_regfile (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .dec0        (dec0),
        .dec1        (dec1),
        .wr0         (wr0),
        .wr1         (wr1),
        .opr0        (opr0),
        .opr1        (opr1),
        .hazard_hold (hazard_hold)
    );

    alu_execute i_execute (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .flush (flush),
        .opr0  (opr0),
        .opr1  (opr1),
        .wr0   (wr0),
        .wr1   (wr1),
        .ex0   (ex0),
        .ex1   (ex1)
    );

    // write ports double as the retire record
    result_writeback i_writeback (
        .clk   (clk),
        .rst_n (rst_n),
        .stall (stall),
        .ex0   (ex0),
        .ex1   (ex1),
        .wr0   (wr0),
        .wr1   (wr1)
    );

    assign issue_hold = hazard_hold;
    assign commit0    = wr0;
    assign commit1    = wr1;

endmodule

//--- hdl/result_writeback.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module result_writeback
    import dual_issue_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  ex_result_t ex0,
    input  ex_result_t ex1,
    output commit_t    wr0,
    output commit_t    wr1
);

    function automatic commit_t finish(input ex_result_t e);
        commit_t               c;
        logic [2*`DI_XLEN-1:0] prod;
        // pp_hh only reaches the upper half, which is dropped
        prod = {{`DI_XLEN{1'b0}}, e.pp_ll} +
               ({{`DI_XLEN{1'b0}}, e.pp_lh} << `DI_HALF) +
               ({{`DI_XLEN{1'b0}}, e.pp_hl} << `DI_HALF) +
               {e.pp_hh, {`DI_XLEN{1'b0}}};
        c.valid     = e.valid;
        c.writes_rd = e.writes_rd;
        c.rd        = e.rd;
        c.pc        = e.pc;
        c.data      = e.is_mul ? prod[`DI_XLEN-1:0] : e.alu_res;
        return c;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr0 <= '0;
            wr1 <= '0;
        end else if (!stall) begin
            wr0 <= finish(ex0);
            wr1 <= finish(ex1);
        end
    end

endmodule

//--- hdl/alu_execute.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module alu_execute
    import dual_issue_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       flush,
    input  operand_t   opr0,
    input  operand_t   opr1,
    input  commit_t    wr0,
    input  commit_t    wr1,
    output ex_result_t ex0,
    output ex_result_t ex1
);

    ex_result_t ex0_n;
    ex_result_t ex1_n;

    // newest producer wins, multiplies in ex are still unfinished
    function automatic logic [`DI_XLEN-1:0] forward(
        input logic [`DI_REG_AW-1:0] addr,
        input logic [`DI_XLEN-1:0]   base,
        input ex_result_t            e0,
        input ex_result_t            e1,
        input commit_t               w0,
        input commit_t               w1
    );
        if (addr == '0) begin
            return base;
        end else if (e1.valid && e1.writes_rd && !e1.is_mul && e1.rd == addr) begin
            return e1.alu_res;
        end else if (e0.valid && e0.writes_rd && !e0.is_mul && e0.rd == addr) begin
            return e0.alu_res;
        end else if (w1.valid && w1.writes_rd && w1.rd == addr) begin
            return w1.data;
        end else if (w0.valid && w0.writes_rd && w0.rd == addr) begin
            return w0.data;
        end
        return base;
    endfunction

    function automatic ex_result_t exec_lane(
        input operand_t   o,
        input ex_result_t e0,
        input ex_result_t e1,
        input commit_t    w0,
        input commit_t    w1
    );
        ex_result_t          r;
        logic [`DI_XLEN-1:0] a;
        logic [`DI_XLEN-1:0] b;
        a = o.op1;
        b = o.op2;
        if (o.uop.src1_sel == SRC1_REG) begin
            a = forward(o.uop.rj, o.op1, e0, e1, w0, w1);
        end
        if (o.uop.src2_sel == SRC2_REG) begin
            b = forward(o.uop.rk, o.op2, e0, e1, w0, w1);
        end
        r.valid     = o.uop.valid;
        r.is_mul    = o.uop.is_mul;
        r.writes_rd = o.uop.writes_rd;
        r.rd        = o.uop.rd;
        r.pc        = o.uop.pc;
        r.alu_res   = '0;
        case (o.uop.alu_fn)
            ALU_ADD: r.alu_res = a + b;
            ALU_SUB: r.alu_res = a - b;
            ALU_AND: r.alu_res = a & b;
            ALU_OR:  r.alu_res = a | b;
            ALU_XOR: r.alu_res = a ^ b;
            ALU_SLT: r.alu_res[0] = $signed(a) < $signed(b);
            default: r.alu_res = b;
        endcase
        r.pp_ll = a[`DI_HALF-1:0] * b[`DI_HALF-1:0];
        r.pp_lh = a[`DI_HALF-1:0] * b[`DI_XLEN-1:`DI_HALF];
        r.pp_hl = a[`DI_XLEN-1:`DI_HALF] * b[`DI_HALF-1:0];
        r.pp_hh = a[`DI_XLEN-1:`DI_HALF] * b[`DI_XLEN-1:`DI_HALF];
        return r;
    endfunction

    always_comb begin
        ex0_n = exec_lane(opr0, ex0, ex1, wr0, wr1);
        ex1_n = exec_lane(opr1, ex0, ex1, wr0, wr1);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex0 <= '0;
            ex1 <= '0;
        end else if (flush) begin
            ex0.valid <= 1'b0;
            ex1.valid <= 1'b0;
        end else if (!stall) begin
            ex0 <= ex0_n;
            ex1 <= ex1_n;
        end
    end

endmodule

//--- hdl/regfile_read.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module regfile_read
    import dual_issue_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     stall,
    input  logic     flush,
    input  uop_t     dec0,
    input  uop_t     dec1,
    input  commit_t  wr0,
    input  commit_t  wr1,
    output operand_t opr0,
    output operand_t opr1,
    output logic     hazard_hold
);

    logic [`DI_XLEN-1:0]  rf [0:(1 << `DI_REG_AW)-1];
    logic [`DI_CNT_W-1:0] cycle_cnt;
    logic                 we0;
    logic                 we1;
    operand_t             opr0_n;
    operand_t             opr1_n;

    // register read with bypass of this cycle's writes, port 1 first
    function automatic logic [`DI_XLEN-1:0] read_reg(
        input logic [`DI_REG_AW-1:0] addr,
        input logic [`DI_XLEN-1:0]   rf_val,
        input commit_t               w0,
        input commit_t               w1
    );
        if (addr == '0) begin
            return '0;
        end else if (w1.valid && w1.writes_rd && w1.rd == addr) begin
            return w1.data;
        end else if (w0.valid && w0.writes_rd && w0.rd == addr) begin
            return w0.data;
        end
        return rf_val;
    endfunction

    function automatic operand_t select_ops(
        input uop_t                 u,
        input logic [`DI_XLEN-1:0]  rj_val,
        input logic [`DI_XLEN-1:0]  rk_val,
        input logic [`DI_CNT_W-1:0] cnt
    );
        operand_t o;
        o.uop = u;
        case (u.src1_sel)
            SRC1_REG: o.op1 = rj_val;
            SRC1_PC:  o.op1 = u.pc;
            default:  o.op1 = '0;
        endcase
        case (u.src2_sel)
            SRC2_REG:    o.op2 = rk_val;
            SRC2_IMM:    o.op2 = u.imm;
            SRC2_CNT_LO: o.op2 = cnt[`DI_XLEN-1:0];
            default:     o.op2 = cnt[`DI_CNT_W-1:`DI_XLEN];
        endcase
        return o;
    endfunction

    function automatic logic reads_reg(input uop_t u, input logic [`DI_REG_AW-1:0] r);
        return u.valid && ((u.src1_sel == SRC1_REG && u.rj == r) ||
                           (u.src2_sel == SRC2_REG && u.rk == r));
    endfunction

    // same-address writes go to port 1 only
    assign we1 = wr1.valid && wr1.writes_rd;
    assign we0 = wr0.valid && wr0.writes_rd && !(we1 && wr1.rd == wr0.rd);

    always_ff @(posedge clk) begin
        if (!stall) begin
            if (we0) begin
                rf[wr0.rd] <= (wr0.rd == '0) ? '0 : wr0.data;
            end
            if (we1) begin
                rf[wr1.rd] <= (wr1.rd == '0) ? '0 : wr1.data;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else begin
            cycle_cnt <= cycle_cnt + 1'b1;
        end
    end

    // multiply result is not ready for a reader right behind it
    assign hazard_hold = opr0.uop.valid && opr0.uop.is_mul && opr0.uop.rd != '0 &&
                         (reads_reg(dec0, opr0.uop.rd) || reads_reg(dec1, opr0.uop.rd));

    always_comb begin
        opr0_n = select_ops(dec0, read_reg(dec0.rj, rf[dec0.rj], wr0, wr1),
                            read_reg(dec0.rk, rf[dec0.rk], wr0, wr1), cycle_cnt);
        opr1_n = select_ops(dec1, read_reg(dec1.rj, rf[dec1.rj], wr0, wr1),
                            read_reg(dec1.rk, rf[dec1.rk], wr0, wr1), cycle_cnt);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            opr0 <= '0;
            opr1 <= '0;
        end else if (flush) begin
            opr0.uop.valid <= 1'b0;
            opr1.uop.valid <= 1'b0;
        end else if (!stall) begin
            opr0 <= opr0_n;
            opr1 <= opr1_n;
            // bubble both lanes on hazard
            opr0.uop.valid <= dec0.valid && !hazard_hold;
            opr1.uop.valid <= dec1.valid && !hazard_hold;
        end
    end

endmodule

//--- hdl/uop_decode.sv
`timescale 1ns/1ps
`include "dual_issue_macros.svh"

module uop_decode
    import dual_issue_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       stall,
    input  logic       flush,
    input  logic       hazard_hold,
    input  issue_pkt_t issue0,
    input  issue_pkt_t issue1,
    output uop_t       dec0,
    output uop_t       dec1
);

    function automatic uop_t decode_lane(input issue_pkt_t p);
        uop_t u;
        u.valid     = p.valid;
        u.is_mul    = 1'b0;
        u.alu_fn    = ALU_ADD;
        u.src1_sel  = SRC1_REG;
        u.src2_sel  = SRC2_REG;
        u.writes_rd = 1'b1;
        u.rd        = p.rd;
        u.rj        = p.rj;
        u.rk        = p.rk;
        u.imm       = p.imm;
        u.pc        = p.pc;
        case (p.opcode)
            OP_ADD: u.alu_fn = ALU_ADD;
            OP_SUB: u.alu_fn = ALU_SUB;
            OP_AND: u.alu_fn = ALU_AND;
            OP_OR:  u.alu_fn = ALU_OR;
            OP_XOR: u.alu_fn = ALU_XOR;
            OP_SLT: u.alu_fn = ALU_SLT;
            OP_ADDI: u.src2_sel = SRC2_IMM;
            OP_LU12I: begin
                // upper immediate, low 20 bits of imm land in [31:12]
                u.alu_fn   = ALU_PASS_B;
                u.src1_sel = SRC1_ZERO;
                u.src2_sel = SRC2_IMM;
                u.imm      = {p.imm[`DI_XLEN-13:0], 12'b0};
            end
            OP_PCADDI: begin
                u.src1_sel = SRC1_PC;
                u.src2_sel = SRC2_IMM;
            end
            OP_MUL: u.is_mul = 1'b1;
            OP_RDCNTL: begin
                u.alu_fn   = ALU_PASS_B;
                u.src1_sel = SRC1_ZERO;
                u.src2_sel = SRC2_CNT_LO;
            end
            OP_RDCNTH: begin
                u.alu_fn   = ALU_PASS_B;
                u.src1_sel = SRC1_ZERO;
                u.src2_sel = SRC2_CNT_HI;
            end
            default: begin
                // nop and anything unknown
                u.writes_rd = 1'b0;
                u.src1_sel  = SRC1_ZERO;
                u.src2_sel  = SRC2_IMM;
            end
        endcase
        return u;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec0 <= '0;
            dec1 <= '0;
        end else if (flush) begin
            dec0.valid <= 1'b0;
            dec1.valid <= 1'b0;
        end else if (!stall && !hazard_hold) begin
            dec0 <= decode_lane(issue0);
            dec1 <= decode_lane(issue1);
        end
    end

endmodule

//--- hdl/dual_issue_pkg.sv
`include "dual_issue_macros.svh"

package dual_issue_pkg;

    typedef enum logic [3:0] {
        OP_NOP, OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT,
        OP_ADDI, OP_LU12I, OP_PCADDI, OP_MUL, OP_RDCNTL, OP_RDCNTH
    } opcode_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_PASS_B
    } alu_fn_e;

    typedef enum logic [1:0] {SRC1_REG, SRC1_PC, SRC1_ZERO} src1_sel_e;

    typedef enum logic [1:0] {SRC2_REG, SRC2_IMM, SRC2_CNT_LO, SRC2_CNT_HI} src2_sel_e;

    typedef struct packed {
        logic                  valid;
        opcode_e               opcode;
        logic [`DI_REG_AW-1:0] rd;
        logic [`DI_REG_AW-1:0] rj;
        logic [`DI_REG_AW-1:0] rk;
        logic [`DI_XLEN-1:0]   imm;
        logic [`DI_XLEN-1:0]   pc;
    } issue_pkt_t;

    typedef struct packed {
        logic                  valid;
        logic                  is_mul;
        alu_fn_e               alu_fn;
        src1_sel_e             src1_sel;
        src2_sel_e             src2_sel;
        logic                  writes_rd;
        logic [`DI_REG_AW-1:0] rd;
        logic [`DI_REG_AW-1:0] rj;
        logic [`DI_REG_AW-1:0] rk;
        logic [`DI_XLEN-1:0]   imm;
        logic [`DI_XLEN-1:0]   pc;
    } uop_t;

    typedef struct packed {
        uop_t                uop;
        logic [`DI_XLEN-1:0] op1;
        logic [`DI_XLEN-1:0] op2;
    } operand_t;

    // pp_xy: x half of op1 times y half of op2, l = low, h = high
    typedef struct packed {
        logic                  valid;
        logic                  is_mul;
        logic                  writes_rd;
        logic [`DI_REG_AW-1:0] rd;
        logic [`DI_XLEN-1:0]   pc;
        logic [`DI_XLEN-1:0]   alu_res;
        logic [`DI_XLEN-1:0]   pp_ll;
        logic [`DI_XLEN-1:0]   pp_lh;
        logic [`DI_XLEN-1:0]   pp_hl;
        logic [`DI_XLEN-1:0]   pp_hh;
    } ex_result_t;

    typedef struct packed {
        logic                  valid;
        logic                  writes_rd;
        logic [`DI_REG_AW-1:0] rd;
        logic [`DI_XLEN-1:0]   pc;
        logic [`DI_XLEN-1:0]   data;
    } commit_t;

endpackage

//--- hdl/dual_issue_macros.svh
`ifndef DUAL_ISSUE_MACROS_SVH
`define DUAL_ISSUE_MACROS_SVH

// datapath width
`define DI_XLEN 32

// half word, used by the multiply partial products
`define DI_HALF 16

// register address width, 32 entries
`define DI_REG_AW 5

// free-running cycle counter
`define DI_CNT_W 64

`endif
